// ==== Makefile ====
# Verilator build and run for the correlator testbench.

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_corr_top \
		-f compile.f --Mdir obj_dir -o sim_corr
	./obj_dir/sim_corr | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
hw/corr_pkg.sv
hw/corr_reg_pkg.sv
hw/single_corr.sv
hw/corr_trigger.sv
hw/corr_regs.sv
hw/corr_top.sv
verif/tb_corr_top.sv

// ==== hw/corr_pkg.sv ====
`default_nettype none

// Types and pipeline constants for the three-antenna power-sum correlator.
// Everything that describes the sample stream and the correlation value lives here.
package corr_pkg;

	// Width of one demultiplexed sample code.
	localparam int NBITS = 3;

	// Number of entries that arrive together in one frame.
	localparam int DEMUX = 16;

	// Extra output delay stages after the previous-frame combine.
	localparam int CORR_DELAY = 2;

	// The four fixed stages are squarer, partial sum, frame sum and combine.
	// The delay stages come on top of those.
	localparam int CORR_LATENCY = 4 + CORR_DELAY;

	// A sample code c is two's complement and stands for the level c+0.5.
	typedef logic signed [NBITS-1:0] sample_t;

	// All samples of one channel in one frame, with entry 0 in the low bits.
	typedef logic [DEMUX*NBITS-1:0] chan_word_t;

	// One frame carries the same entries from all three antennas.
	typedef struct packed {
		chan_word_t a;
		chan_word_t b;
		chan_word_t c;
	} corr_frame_t;

	// Offset squarer term q = (s+1)(s+2)/2, which peaks at 55.
	typedef logic [5:0] sq_term_t;

	// Correlation value over 32 entries, at most 3528.
	typedef logic [11:0] corr_t;

endpackage

`default_nettype wire

// ==== hw/corr_reg_pkg.sv ====
`default_nettype none

// Register map of the correlator and the APB bus types used to reach it.
package corr_reg_pkg;

	typedef logic [7:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// Number of triggers seen since reset or the last clear.
	typedef logic [15:0] trig_count_t;

	// Request side of the APB bus, as driven by the master.
	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	// Response side of the APB bus, as driven by the slave.
	typedef struct packed {
		apb_data_t prdata;
		logic      pready;
		logic      pslverr;
	} apb_rsp_t;

	// Register addresses. PEAK, TRIG_CNT and LAST are read only.
	localparam apb_addr_t ADDR_CTRL     = 8'h00;
	localparam apb_addr_t ADDR_THRESH   = 8'h04;
	localparam apb_addr_t ADDR_PEAK     = 8'h08;
	localparam apb_addr_t ADDR_TRIG_CNT = 8'h0C;
	localparam apb_addr_t ADDR_LAST     = 8'h10;

	// Bit positions inside CTRL.
	localparam int CTRL_ENABLE_BIT = 0;
	localparam int CTRL_CLEAR_BIT  = 1;

	// Control from the register block into the datapath.
	// The clear_stats bit is a single-cycle pulse.
	typedef struct packed {
		logic            enable;
		logic            clear_stats;
		corr_pkg::corr_t threshold;
	} corr_ctrl_t;

	// Statistics from the trigger stage back into the register block.
	typedef struct packed {
		corr_pkg::corr_t peak;
		trig_count_t     trig_count;
		corr_pkg::corr_t last_corr;
	} corr_stat_t;

endpackage

`default_nettype wire

// ==== hw/corr_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

// APB register block for the correlator.
// CTRL holds the enable bit and launches the statistics clear. THRESH holds the trigger
// threshold. PEAK, TRIG_CNT and LAST show the statistics of the trigger stage.
// The slave never inserts wait states, so every access ends in its access cycle.
module corr_regs (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  corr_reg_pkg::apb_req_t   apb_req_i,
	output corr_reg_pkg::apb_rsp_t   apb_rsp_o,
	input  corr_reg_pkg::corr_stat_t stat_i,
	output corr_reg_pkg::corr_ctrl_t ctrl_o
);

	logic access;
	logic mapped;
	logic read_only;
	logic sel_ctrl;
	logic sel_thresh;
	logic wr_ok;
	logic err;
	corr_reg_pkg::apb_data_t rdata;
	corr_reg_pkg::corr_ctrl_t ctrl_q;

	// The access phase is the second cycle of a transfer.
	assign access = apb_req_i.psel & apb_req_i.penable;

	// Address decode and read mux.
	// Unused bits read as zero, and the clear bit in CTRL always reads back as zero.
	always_comb begin
		mapped = 1'b1;
		read_only = 1'b0;
		sel_ctrl = 1'b0;
		sel_thresh = 1'b0;
		rdata = '0;
		case (apb_req_i.paddr)
			corr_reg_pkg::ADDR_CTRL: begin
				sel_ctrl = 1'b1;
				rdata[corr_reg_pkg::CTRL_ENABLE_BIT] = ctrl_q.enable;
			end
			corr_reg_pkg::ADDR_THRESH: begin
				sel_thresh = 1'b1;
				rdata = corr_reg_pkg::apb_data_t'(ctrl_q.threshold);
			end
			corr_reg_pkg::ADDR_PEAK: begin
				read_only = 1'b1;
				rdata = corr_reg_pkg::apb_data_t'(stat_i.peak);
			end
			corr_reg_pkg::ADDR_TRIG_CNT: begin
				read_only = 1'b1;
				rdata = corr_reg_pkg::apb_data_t'(stat_i.trig_count);
			end
			corr_reg_pkg::ADDR_LAST: begin
				read_only = 1'b1;
				rdata = corr_reg_pkg::apb_data_t'(stat_i.last_corr);
			end
			default: begin
				mapped = 1'b0;
			end
		endcase
	end

	// A write that raises an error changes nothing.
	assign err = access & (~mapped | (apb_req_i.pwrite & read_only));
	assign wr_ok = access & apb_req_i.pwrite & ~err;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ctrl_q.enable <= 1'b0;
			ctrl_q.clear_stats <= 1'b0;
			// Threshold starts at full scale, so nothing triggers until it is set.
			ctrl_q.threshold <= '1;
		end else begin
			// The clear bit is a pulse and drops again after one cycle.
			ctrl_q.clear_stats <= 1'b0;
			if (wr_ok && sel_ctrl) begin
				ctrl_q.enable <= apb_req_i.pwdata[corr_reg_pkg::CTRL_ENABLE_BIT];
				ctrl_q.clear_stats <= apb_req_i.pwdata[corr_reg_pkg::CTRL_CLEAR_BIT];
			end
			if (wr_ok && sel_thresh) begin
				ctrl_q.threshold <= apb_req_i.pwdata[$bits(corr_pkg::corr_t)-1:0];
			end
		end
	end

	assign ctrl_o = ctrl_q;

	// pready is tied high since there are no wait states.
	assign apb_rsp_o = '{prdata: rdata, pready: 1'b1, pslverr: err};

endmodule

`default_nettype wire

// ==== hw/corr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Top level of the correlator subsystem.
// The register block steers the correlator and the trigger stage. The correlation result
// goes out of the block and into the trigger stage at the same time.
module corr_top (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  corr_pkg::corr_frame_t  frame_i,
	input  logic                   frame_valid_i,
	input  corr_reg_pkg::apb_req_t apb_req_i,
	output corr_reg_pkg::apb_rsp_t apb_rsp_o,
	output corr_pkg::corr_t        corr_o,
	output logic                   corr_valid_o,
	output logic                   trig_o
);

	// Control from the registers and statistics back to them.
	corr_reg_pkg::corr_ctrl_t ctrl;
	corr_reg_pkg::corr_stat_t stat;

	corr_regs u_regs (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.apb_req_i (apb_req_i),
		.apb_rsp_o (apb_rsp_o),
		.stat_i    (stat),
		.ctrl_o    (ctrl)
	);

	// The delay sets the total latency to CORR_LATENCY.
	single_corr #(
		.DELAY (corr_pkg::CORR_DELAY)
	) u_corr (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.en_i          (ctrl.enable),
		.frame_i       (frame_i),
		.frame_valid_i (frame_valid_i),
		.corr_o        (corr_o),
		.corr_valid_o  (corr_valid_o)
	);

	corr_trigger u_trig (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.corr_i       (corr_o),
		.corr_valid_i (corr_valid_o),
		.threshold_i  (ctrl.threshold),
		.clear_i      (ctrl.clear_stats),
		.trig_o       (trig_o),
		.stat_o       (stat)
	);

endmodule

`default_nettype wire

// ==== hw/corr_trigger.sv ====
`timescale 1ns/1ps
`default_nettype none

// Trigger stage behind the correlator.
// Every valid correlation is compared against the threshold. A hit gives a one-cycle
// trigger pulse and bumps a saturating counter. The stage also keeps the peak and the
// most recent valid value for the register block.
module corr_trigger (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  corr_pkg::corr_t          corr_i,
	input  logic                     corr_valid_i,
	input  corr_pkg::corr_t          threshold_i,
	input  logic                     clear_i,
	output logic                     trig_o,
	output corr_reg_pkg::corr_stat_t stat_o
);

	logic hit;
	logic trig_q;
	corr_reg_pkg::corr_stat_t stat_q;

	// A value equal to the threshold also triggers.
	assign hit = corr_valid_i && (corr_i >= threshold_i);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			trig_q <= 1'b0;
			stat_q <= '0;
		end else begin
			// The pulse and the statistics update on the same edge.
			trig_q <= hit;

			// Clear wins over an update in the same cycle.
			if (clear_i) begin
				stat_q.peak <= '0;
				stat_q.trig_count <= '0;
			end else begin
				// The counter sticks at all ones instead of wrapping.
				if (hit && (stat_q.trig_count != '1)) begin
					stat_q.trig_count <= stat_q.trig_count + 1'b1;
				end
				// Peak looks at every valid value, not just triggers.
				if (corr_valid_i && (corr_i > stat_q.peak)) begin
					stat_q.peak <= corr_i;
				end
			end

			// last value is not touched by clear
			if (corr_valid_i) begin
				stat_q.last_corr <= corr_i;
			end
		end
	end

	assign trig_o = trig_q;
	assign stat_o = stat_q;

endmodule

`default_nettype wire

// ==== hw/single_corr.sv ====
`timescale 1ns/1ps
`default_nettype none

// Power-sum correlator for three antennas.
// Each frame brings 16 entries per antenna. The module adds the three codes of every entry,
// squares the sum with the 1.5 offset folded in, and reduces the 16 terms in a registered
// adder tree. The frame sum is added to the previous frame sum, so every result covers the
// 32 most recent entries. The value is exactly the sum of (s+1.5)^2 over those entries.
module single_corr #(
	parameter int DELAY = 2
) (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  en_i,
	input  corr_pkg::corr_frame_t frame_i,
	input  logic                  frame_valid_i,
	output corr_pkg::corr_t       corr_o,
	output logic                  corr_valid_o
);

	// Sum of three codes, -12 to 9.
	typedef logic signed [4:0] esum_t;
	// Sum of four squarer terms, at most 220.
	typedef logic [7:0] part_t;
	// Sum of 16 squarer terms, at most 880.
	typedef logic [9:0] fsum_t;
	// Half of the correlation value, before the final doubling.
	typedef logic [$bits(corr_pkg::corr_t)-2:0] half_t;

	// Maps an entry sum s to q = (s+1)(s+2)/2.
	// Since (s+1.5)^2 = 2q + 0.25, the dropped quarter is put back once per frame pair later on.
	// The table is symmetric about s = -1.5, so s and -3-s share a line.
	function automatic corr_pkg::sq_term_t sq_term(input esum_t s);
		corr_pkg::sq_term_t q;
		case (s)
			-12, 9:  q = 6'd55;
			-11, 8:  q = 6'd45;
			-10, 7:  q = 6'd36;
			-9, 6:   q = 6'd28;
			-8, 5:   q = 6'd21;
			-7, 4:   q = 6'd15;
			-6, 3:   q = 6'd10;
			-5, 2:   q = 6'd6;
			-4, 1:   q = 6'd3;
			-3, 0:   q = 6'd1;
			default: q = 6'd0;
		endcase
		return q;
	endfunction

	logic acc;
	logic acc_q;
	esum_t esum [corr_pkg::DEMUX];

	corr_pkg::sq_term_t sq_q [corr_pkg::DEMUX];
	logic sq_vld_q;
	part_t part_q [corr_pkg::DEMUX/4];
	logic part_vld_q;
	fsum_t fsum_q;
	fsum_t fsum_prev_q;
	logic fsum_vld_q;

	// Index 0 is the combine stage and index DELAY drives the output.
	half_t half_q [DELAY+1];
	logic [DELAY:0] vld_q;

	// A frame only counts while the correlator is enabled.
	assign acc = frame_valid_i & en_i;

	// Entry sums. The casts make each code signed, so it is sign-extended to five bits.
	always_comb begin
		for (int i = 0; i < corr_pkg::DEMUX; i++) begin
			esum[i] = corr_pkg::sample_t'(frame_i.a[i*corr_pkg::NBITS +: corr_pkg::NBITS])
				+ corr_pkg::sample_t'(frame_i.b[i*corr_pkg::NBITS +: corr_pkg::NBITS])
				+ corr_pkg::sample_t'(frame_i.c[i*corr_pkg::NBITS +: corr_pkg::NBITS]);
		end
	end

	// The valid tag follows the data stage by stage.
	// A result needs the current and the previous frame both accepted, back to back.
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			acc_q <= 1'b0;
			sq_vld_q <= 1'b0;
			part_vld_q <= 1'b0;
			fsum_vld_q <= 1'b0;
			vld_q <= '0;
		end else begin
			acc_q <= acc;
			sq_vld_q <= acc & acc_q;
			part_vld_q <= sq_vld_q;
			fsum_vld_q <= part_vld_q;
			vld_q[0] <= fsum_vld_q;
			for (int m = 1; m <= DELAY; m++) begin
				vld_q[m] <= vld_q[m-1];
			end
		end
	end

	// The datapath runs freely. Bubbles are only marked by the valid tag.
	always_ff @(posedge clk) begin
		// Squarer terms are taken straight from the frame on the accepting edge.
		for (int i = 0; i < corr_pkg::DEMUX; i++) begin
			sq_q[i] <= sq_term(esum[i]);
		end
		// First tree level adds four neighbouring terms at once.
		for (int j = 0; j < corr_pkg::DEMUX/4; j++) begin
			part_q[j] <= part_t'(sq_q[4*j]) + part_t'(sq_q[4*j+1])
				+ part_t'(sq_q[4*j+2]) + part_t'(sq_q[4*j+3]);
		end
		// Second level closes the frame.
		fsum_q <= fsum_t'(part_q[0]) + fsum_t'(part_q[1])
			+ fsum_t'(part_q[2]) + fsum_t'(part_q[3]);
		// One frame later this is the previous frame sum.
		fsum_prev_q <= fsum_q;
		// 32 entries each lost 0.25, which is 8 in total and 4 at half scale.
		half_q[0] <= half_t'(fsum_q) + half_t'(fsum_prev_q) + half_t'(4);
		for (int m = 1; m <= DELAY; m++) begin
			half_q[m] <= half_q[m-1];
		end
	end

	// Doubling restores the full scale of the power sum.
	assign corr_o = {half_q[DELAY], 1'b0};
	assign corr_valid_o = vld_q[DELAY];

endmodule

`default_nettype wire

// ==== verif/tb_corr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Directed testbench for the correlator subsystem.
// A monitor compares every result against a queue of expected values built from a
// reference model, and checks the arrival cycle and the trigger pulse that follows.
module tb_corr_top;

	logic clk;
	logic rst_n_i;
	corr_pkg::corr_frame_t frame_i;
	logic frame_valid_i;
	corr_reg_pkg::apb_req_t apb_req_i;
	corr_reg_pkg::apb_rsp_t apb_rsp_o;
	corr_pkg::corr_t corr_o;
	logic corr_valid_o;
	logic trig_o;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int results = 0;
	int cyc = 0;
	logic [31:0] rng = 32'd3;

	// Software view of the register state, kept in step with the APB writes.
	bit tb_enable = 1'b0;
	bit prev_acc = 1'b0;
	corr_pkg::corr_frame_t prev_frame;
	corr_pkg::corr_t tb_thresh = 12'hFFF;

	// Statistics the trigger stage should hold.
	corr_pkg::corr_t m_peak = '0;
	corr_pkg::corr_t m_last = '0;
	int m_trig_cnt = 0;
	bit trig_exp = 1'b0;

	// Expected results and the cycle in which each one must appear.
	corr_pkg::corr_t exp_val_q [$];
	int exp_cyc_q [$];
	corr_pkg::corr_t ev;
	int ec;

	corr_top u_corr_top (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.frame_i       (frame_i),
		.frame_valid_i (frame_valid_i),
		.apb_req_i     (apb_req_i),
		.apb_rsp_o     (apb_rsp_o),
		.corr_o        (corr_o),
		.corr_valid_o  (corr_valid_o),
		.trig_o        (trig_o)
	);

	always #2 clk = ~clk;

	// Counts rising edges so that latency can be checked in whole cycles.
	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// Outputs are sampled on the falling edge, half a cycle away from any update.
	always @(negedge clk) begin
		if (rst_n_i) begin
			if (trig_o !== trig_exp) begin
				$display("MISMATCH at %0t: trig_o expected %0b got %0b", $time, trig_exp, trig_o);
				errors++;
			end
			trig_exp = 1'b0;
			if (corr_valid_o === 1'b1) begin
				results++;
				if (exp_val_q.size() == 0) begin
					$display("ERROR at %0t: corr_valid_o high with no result expected", $time);
					errors++;
				end else begin
					ev = exp_val_q.pop_front();
					ec = exp_cyc_q.pop_front();
					if (corr_o !== ev) begin
						$display("MISMATCH at %0t: corr_o expected %0d got %0d", $time, ev, corr_o);
						errors++;
					end
					if (cyc != ec) begin
						$display("MISMATCH at %0t: result cycle expected %0d got %0d", $time, ec, cyc);
						errors++;
					end
					// The trigger stage sees the same value one cycle earlier than its outputs.
					m_last = ev;
					if (ev > m_peak) begin
						m_peak = ev;
					end
					if (ev >= tb_thresh) begin
						trig_exp = 1'b1;
						if (m_trig_cnt < 65535) begin
							m_trig_cnt++;
						end
					end
				end
			end else if (corr_valid_o !== 1'b0) begin
				$display("ERROR at %0t: corr_valid_o is unknown", $time);
				errors++;
			end
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Reads entry i of a channel word as a signed code.
	function automatic int code_at(input corr_pkg::chan_word_t w, input int i);
		int v;
		v = int'(w[i*corr_pkg::NBITS +: corr_pkg::NBITS]);
		if (v > 3) begin
			v = v - 8;
		end
		return v;
	endfunction

	// Sum of (2s+3)^2 over the 16 entries of one frame, which is four times the power.
	function automatic int frame_power4(input corr_pkg::corr_frame_t f);
		int s;
		int acc;
		acc = 0;
		for (int i = 0; i < corr_pkg::DEMUX; i++) begin
			s = code_at(f.a, i) + code_at(f.b, i) + code_at(f.c, i);
			acc += (2*s + 3) * (2*s + 3);
		end
		return acc;
	endfunction

	// Every (2s+3)^2 is 1 modulo 4, so 32 of them always divide evenly.
	function automatic corr_pkg::corr_t model_corr(input corr_pkg::corr_frame_t cur,
		input corr_pkg::corr_frame_t prev);
		return corr_pkg::corr_t'((frame_power4(cur) + frame_power4(prev)) / 4);
	endfunction

	function automatic corr_pkg::corr_frame_t const_frame(input logic [2:0] code);
		corr_pkg::corr_frame_t f;
		f.a = {16{code}};
		f.b = {16{code}};
		f.c = {16{code}};
		return f;
	endfunction

	// A correlated frame has the same code on all antennas, like an impulse would.
	task automatic random_frame(input bit correlated, output corr_pkg::corr_frame_t f);
		for (int i = 0; i < corr_pkg::DEMUX; i++) begin
			rng = xorshift32(rng);
			f.a[i*corr_pkg::NBITS +: corr_pkg::NBITS] = rng[2:0];
			f.b[i*corr_pkg::NBITS +: corr_pkg::NBITS] = correlated ? rng[2:0] : rng[5:3];
			f.c[i*corr_pkg::NBITS +: corr_pkg::NBITS] = correlated ? rng[2:0] : rng[8:6];
		end
	endtask

	// Moves to the drive point 1 ns after the next rising edge.
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic send_frame(input corr_pkg::corr_frame_t f);
		frame_i = f;
		frame_valid_i = 1'b1;
		if (tb_enable && prev_acc) begin
			exp_val_q.push_back(model_corr(f, prev_frame));
			exp_cyc_q.push_back(cyc + corr_pkg::CORR_LATENCY);
		end
		prev_acc = tb_enable;
		prev_frame = f;
		step();
	endtask

	task automatic idle_cycle();
		frame_valid_i = 1'b0;
		prev_acc = 1'b0;
		step();
	endtask

	task automatic apb_write(input corr_reg_pkg::apb_addr_t addr,
		input corr_reg_pkg::apb_data_t data, input bit exp_err);
		frame_valid_i = 1'b0;
		prev_acc = 1'b0;
		apb_req_i = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		step();
		apb_req_i.penable = 1'b1;
		@(negedge clk);
		if (apb_rsp_o.pready !== 1'b1) begin
			$display("ERROR at %0t: pready low in write access to 0x%0h", $time, addr);
			errors++;
		end
		if (apb_rsp_o.pslverr !== exp_err) begin
			$display("MISMATCH at %0t: write 0x%0h pslverr expected %0b got %0b",
				$time, addr, exp_err, apb_rsp_o.pslverr);
			errors++;
		end
		step();
		apb_req_i = '0;
	endtask

	task automatic apb_read(input corr_reg_pkg::apb_addr_t addr,
		output corr_reg_pkg::apb_data_t data, input bit exp_err);
		frame_valid_i = 1'b0;
		prev_acc = 1'b0;
		apb_req_i = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
		step();
		apb_req_i.penable = 1'b1;
		@(negedge clk);
		data = apb_rsp_o.prdata;
		if (apb_rsp_o.pready !== 1'b1) begin
			$display("ERROR at %0t: pready low in read access to 0x%0h", $time, addr);
			errors++;
		end
		if (apb_rsp_o.pslverr !== exp_err) begin
			$display("MISMATCH at %0t: read 0x%0h pslverr expected %0b got %0b",
				$time, addr, exp_err, apb_rsp_o.pslverr);
			errors++;
		end
		step();
		apb_req_i = '0;
	endtask

	task automatic check_reg(input corr_reg_pkg::apb_addr_t addr,
		input corr_reg_pkg::apb_data_t exp);
		corr_reg_pkg::apb_data_t d;
		apb_read(addr, d, 1'b0);
		if (d !== exp) begin
			$display("MISMATCH at %0t: register 0x%0h expected 0x%0h got 0x%0h",
				$time, addr, exp, d);
			errors++;
		end
	endtask

	// Waits until every expected result has shown up, then lets the trigger pulse pass.
	task automatic wait_results(input string what);
		int n;
		n = 0;
		while (exp_val_q.size() != 0 && n < 60) begin
			idle_cycle();
			n++;
		end
		if (exp_val_q.size() != 0) begin
			$display("ERROR: %s timed out waiting for corr_valid_o, %0d results never came",
				what, exp_val_q.size());
			errors++;
			exp_val_q.delete();
			exp_cyc_q.delete();
		end
		idle_cycle();
		idle_cycle();
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %s: PASS", name);
		end else begin
			tests_failed++;
			$display("test %s: FAIL with %0d errors", name, errors - err_before);
		end
	endtask

	task automatic test_regs();
		int e0;
		corr_reg_pkg::apb_data_t d;
		e0 = errors;
		check_reg(corr_reg_pkg::ADDR_CTRL, 32'h0);
		check_reg(corr_reg_pkg::ADDR_THRESH, 32'hFFF);
		check_reg(corr_reg_pkg::ADDR_PEAK, 32'h0);
		check_reg(corr_reg_pkg::ADDR_TRIG_CNT, 32'h0);
		check_reg(corr_reg_pkg::ADDR_LAST, 32'h0);
		apb_write(corr_reg_pkg::ADDR_THRESH, 32'h5A5, 1'b0);
		check_reg(corr_reg_pkg::ADDR_THRESH, 32'h5A5);
		// An unmapped address answers with an error in the access cycle.
		apb_read(8'h20, d, 1'b1);
		apb_write(8'h20, 32'h0, 1'b1);
		apb_write(corr_reg_pkg::ADDR_PEAK, 32'h123, 1'b1);
		check_reg(corr_reg_pkg::ADDR_PEAK, 32'h0);
		apb_write(corr_reg_pkg::ADDR_THRESH, 32'hFFF, 1'b0);
		end_test("register reset and readback", e0);
	endtask

	// One pair of equal constant frames gives a single result from the table.
	task automatic const_pair(input logic [2:0] code, input corr_pkg::corr_t table_val);
		corr_pkg::corr_frame_t f;
		f = const_frame(code);
		if (model_corr(f, f) != table_val) begin
			$display("MISMATCH at %0t: model for code %0d expected %0d got %0d",
				$time, $signed(code), table_val, model_corr(f, f));
			errors++;
		end
		send_frame(f);
		send_frame(f);
		idle_cycle();
	endtask

	task automatic test_const();
		int e0;
		int r0;
		e0 = errors;
		apb_write(corr_reg_pkg::ADDR_CTRL, 32'h1, 1'b0);
		tb_enable = 1'b1;
		r0 = results;
		const_pair(3'b000, 12'd72);
		const_pair(3'b011, 12'd3528);
		const_pair(3'b100, 12'd3528);
		const_pair(3'b111, 12'd72);
		wait_results("constant frames");
		if (results - r0 != 4) begin
			$display("MISMATCH at %0t: result count expected 4 got %0d", $time, results - r0);
			errors++;
		end
		end_test("constant frames", e0);
	endtask

	task automatic test_random();
		int e0;
		int r0;
		corr_pkg::corr_frame_t f;
		e0 = errors;
		r0 = results;
		for (int k = 0; k < 40; k++) begin
			random_frame(1'b0, f);
			send_frame(f);
		end
		wait_results("random stream");
		if (results - r0 != 39) begin
			$display("MISMATCH at %0t: result count expected 39 got %0d", $time, results - r0);
			errors++;
		end
		end_test("random stream", e0);
	endtask

	task automatic test_trigger();
		int e0;
		corr_pkg::corr_frame_t f;
		e0 = errors;
		// Start from clean statistics, keeping enable set.
		apb_write(corr_reg_pkg::ADDR_CTRL, 32'h3, 1'b0);
		m_peak = '0;
		m_trig_cnt = 0;
		apb_write(corr_reg_pkg::ADDR_THRESH, 32'd1000, 1'b0);
		tb_thresh = 12'd1000;
		for (int k = 0; k < 40; k++) begin
			rng = xorshift32(rng);
			random_frame(rng[4], f);
			send_frame(f);
		end
		wait_results("trigger stream");
		if (m_trig_cnt == 0) begin
			$display("ERROR: trigger stream produced no value at or above the threshold");
			errors++;
		end
		check_reg(corr_reg_pkg::ADDR_TRIG_CNT, corr_reg_pkg::apb_data_t'(m_trig_cnt));
		check_reg(corr_reg_pkg::ADDR_PEAK, corr_reg_pkg::apb_data_t'(m_peak));
		check_reg(corr_reg_pkg::ADDR_LAST, corr_reg_pkg::apb_data_t'(m_last));
		apb_write(corr_reg_pkg::ADDR_CTRL, 32'h3, 1'b0);
		m_peak = '0;
		m_trig_cnt = 0;
		idle_cycle();
		check_reg(corr_reg_pkg::ADDR_PEAK, 32'h0);
		check_reg(corr_reg_pkg::ADDR_TRIG_CNT, 32'h0);
		check_reg(corr_reg_pkg::ADDR_LAST, corr_reg_pkg::apb_data_t'(m_last));
		// Enable stays set and the clear bit reads back as zero.
		check_reg(corr_reg_pkg::ADDR_CTRL, 32'h1);
		end_test("trigger and statistics", e0);
	endtask

	task automatic test_gaps();
		int e0;
		int r0;
		corr_pkg::corr_frame_t f;
		e0 = errors;
		r0 = results;
		// Frame after an idle cycle starts a new pair and gives nothing by itself.
		random_frame(1'b1, f);
		send_frame(f);
		idle_cycle();
		random_frame(1'b0, f);
		send_frame(f);
		random_frame(1'b1, f);
		send_frame(f);
		wait_results("gap stream");
		if (results - r0 != 1) begin
			$display("MISMATCH at %0t: results after gap expected 1 got %0d", $time, results - r0);
			errors++;
		end
		apb_write(corr_reg_pkg::ADDR_CTRL, 32'h0, 1'b0);
		tb_enable = 1'b0;
		r0 = results;
		for (int k = 0; k < 3; k++) begin
			random_frame(1'b0, f);
			send_frame(f);
		end
		for (int k = 0; k < 20; k++) begin
			idle_cycle();
		end
		if (results != r0) begin
			$display("ERROR: corr_valid_o appeared %0d times while disabled", results - r0);
			errors++;
		end
		apb_write(corr_reg_pkg::ADDR_CTRL, 32'h1, 1'b0);
		tb_enable = 1'b1;
		r0 = results;
		random_frame(1'b0, f);
		send_frame(f);
		random_frame(1'b1, f);
		send_frame(f);
		idle_cycle();
		for (int k = 0; k < 3; k++) begin
			random_frame(1'b0, f);
			send_frame(f);
		end
		wait_results("re-enabled stream");
		if (results - r0 != 3) begin
			$display("MISMATCH at %0t: results after enable expected 3 got %0d",
				$time, results - r0);
			errors++;
		end
		end_test("gaps and disable", e0);
	endtask

	initial begin
		clk = 1'b0;
		rst_n_i = 1'b0;
		frame_i = '0;
		frame_valid_i = 1'b0;
		apb_req_i = '0;
		prev_frame = '0;
		repeat (3) @(posedge clk);
		#1;
		rst_n_i = 1'b1;
		step();

		test_regs();
		test_const();
		test_random();
		test_trigger();
		test_gaps();

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
